// ==== hdl/harness_pkg.sv ====
`default_nettype none

package harness_pkg;

    localparam int MEM_WORDS      = 256;
    localparam int TIMEOUT_CYCLES = 2000; // Run cycles before the core is stopped

    typedef logic [31:0] word_t;
    typedef logic [7:0]  mem_addr_t;  // Word index into the program memory
    typedef logic [31:0] cycle_cnt_t;

    // APB byte offsets
    localparam logic [7:0] REG_CTRL     = 8'h00;
    localparam logic [7:0] REG_STATUS   = 8'h04;
    localparam logic [7:0] REG_MEM_ADDR = 8'h08;
    localparam logic [7:0] REG_MEM_DATA = 8'h0C;
    localparam logic [7:0] REG_CYCLES   = 8'h10;

    // Opcode sits in instr[31:28], operand in instr[15:0]
    typedef enum logic [3:0] {
        OP_HALT = 4'h0, // Cleared memory halts the core
        OP_LDI  = 4'h1,
        OP_LD   = 4'h2,
        OP_ST   = 4'h3,
        OP_ADD  = 4'h4,
        OP_SUB  = 4'h5,
        OP_BNZ  = 4'h6
    } opcode_t;

    typedef enum logic [1:0] {
        FETCH,
        DECODE,
        MEM,
        HALTED
    } core_state_t;

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        word_t      pwdata;
    } apb_req_t;

    typedef struct packed {
        logic  pready;
        word_t prdata;
        logic  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] addr; // Byte address
        word_t       wdata;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        word_t rdata;
    } wb_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/harness_memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module harness_memory import harness_pkg::*; (
    input  logic    sys_clk_i,
    input  logic    rst_n_i,
    input  wb_req_t wb_req_i,
    output wb_rsp_t wb_rsp_o
);

    word_t     mem_q [MEM_WORDS];
    word_t     rdata_q;
    mem_addr_t word_idx;
    logic      ack_q;
    logic      req_new;

    assign word_idx = wb_req_i.addr[9:2]; // Whole words only

    // A request still high on its ack cycle is not taken again
    assign req_new = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_new; // Single-cycle pulse
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (req_new) begin
            if (wb_req_i.we) begin
                mem_q[word_idx] <= wb_req_i.wdata;
            end
            rdata_q <= mem_q[word_idx]; // Old word on a write
        end
    end

    assign wb_rsp_o.ack   = ack_q;
    assign wb_rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hdl/harness_controller.sv ====
`timescale 1ns/1ns
`default_nettype none

module harness_controller import harness_pkg::*; (
    input  logic     sys_clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o,
    input  wb_req_t  core_wb_req_i,
    output wb_rsp_t  core_wb_rsp_o,
    input  logic     halted_i,
    output logic     core_run_o
);

    logic       run_q;
    logic       halted_q;
    logic       timeout_q;
    logic       stop_pend_q;  // Host asked to clear run
    mem_addr_t  mem_addr_q;
    cycle_cnt_t cycles_q;

    wb_req_t host_req;
    wb_req_t mem_req;
    wb_rsp_t mem_rsp;

    logic apb_access;
    logic is_mem_data;
    logic mapped;
    logic host_mem;
    logic wr_done;
    logic timeout_hit;
    logic core_busy;
    logic stop_req;

    assign apb_access  = apb_req_i.psel && apb_req_i.penable;
    assign is_mem_data = apb_req_i.paddr == REG_MEM_DATA;
    assign mapped      = apb_req_i.paddr inside {REG_CTRL, REG_STATUS, REG_MEM_ADDR,
                                                 REG_MEM_DATA, REG_CYCLES};
    assign host_mem    = apb_access && is_mem_data && !run_q;

    assign apb_rsp_o.pslverr = apb_access && (!mapped || (is_mem_data && run_q));
    assign apb_rsp_o.pready  = apb_access && (!host_mem || mem_rsp.ack); // One wait state
    assign wr_done = apb_rsp_o.pready && apb_req_i.pwrite && !apb_rsp_o.pslverr;

    always_comb begin
        case (apb_req_i.paddr)
            REG_CTRL:     apb_rsp_o.prdata = {31'b0, run_q};
            REG_STATUS:   apb_rsp_o.prdata = {30'b0, timeout_q, halted_q};
            REG_MEM_ADDR: apb_rsp_o.prdata = {24'b0, mem_addr_q};
            REG_MEM_DATA: apb_rsp_o.prdata = mem_rsp.rdata;
            REG_CYCLES:   apb_rsp_o.prdata = cycles_q;
            default:      apb_rsp_o.prdata = '0;
        endcase
    end

    assign timeout_hit = cycles_q == cycle_cnt_t'(TIMEOUT_CYCLES);
    assign core_busy   = core_wb_req_i.cyc && !mem_rsp.ack; // Core waits on an ack
    assign stop_req    = stop_pend_q || timeout_hit || halted_i;

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q       <= 1'b0;
            halted_q    <= 1'b0;
            timeout_q   <= 1'b0;
            stop_pend_q <= 1'b0;
            mem_addr_q  <= '0;
            cycles_q    <= '0;
        end else begin
            if (run_q && !halted_i && !timeout_hit) begin
                cycles_q <= cycles_q + 1'b1;
            end
            if (run_q && halted_i) begin
                halted_q <= 1'b1;
            end
            // Run only drops between core bus cycles
            if (run_q && stop_req && !core_busy) begin
                run_q       <= 1'b0;
                stop_pend_q <= 1'b0;
                timeout_q   <= timeout_hit;
            end
            if (host_mem && mem_rsp.ack) begin
                mem_addr_q <= mem_addr_q + 1'b1; // Auto-increment on read and write
            end
            if (wr_done) begin
                case (apb_req_i.paddr)
                    REG_CTRL: begin
                        if (apb_req_i.pwdata[0]) begin
                            run_q       <= 1'b1;
                            cycles_q    <= '0;
                            halted_q    <= 1'b0;
                            timeout_q   <= 1'b0;
                            stop_pend_q <= 1'b0;
                        end else if (run_q) begin
                            stop_pend_q <= 1'b1;
                        end
                    end
                    REG_MEM_ADDR: mem_addr_q <= apb_req_i.pwdata[7:0];
                    default: ;
                endcase
            end
        end
    end

    assign host_req.cyc   = host_mem;
    assign host_req.stb   = host_mem;
    assign host_req.we    = apb_req_i.pwrite;
    assign host_req.addr  = {22'b0, mem_addr_q, 2'b00};
    assign host_req.wdata = apb_req_i.pwdata;

    assign mem_req = run_q ? core_wb_req_i : host_req;

    assign core_wb_rsp_o.ack   = mem_rsp.ack && run_q;
    assign core_wb_rsp_o.rdata = mem_rsp.rdata;
    assign core_run_o          = run_q;

    harness_memory u_memory (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .wb_req_i  (mem_req),
        .wb_rsp_o  (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== hdl/accum_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module accum_core import harness_pkg::*; (
    input  logic    sys_clk_i,
    input  logic    rst_n_i,
    input  logic    run_i,
    output wb_req_t wb_req_o,
    input  wb_rsp_t wb_rsp_i,
    output logic    halted_o
);

    core_state_t state_q;
    mem_addr_t   pc_q;
    word_t       ir_q;
    word_t       acc_q;

    opcode_t   op;
    mem_addr_t operand_addr;
    mem_addr_t pc_next;
    logic      bus_state;

    assign op           = opcode_t'(ir_q[31:28]);
    assign operand_addr = ir_q[7:0]; // Upper operand bits only matter for LDI
    assign pc_next      = pc_q + 1'b1;
    assign bus_state    = (state_q == FETCH) || (state_q == MEM);

    always_ff @(posedge sys_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= FETCH;
            pc_q    <= '0;
            ir_q    <= '0;
            acc_q   <= '0;
        end else if (!run_i) begin
            // Idle, ready to start at word 0
            state_q <= FETCH;
            pc_q    <= '0;
            acc_q   <= '0;
        end else begin
            case (state_q)
                FETCH: begin
                    if (wb_rsp_i.ack) begin
                        ir_q    <= wb_rsp_i.rdata;
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    case (op)
                        OP_LDI: begin
                            acc_q   <= {16'b0, ir_q[15:0]};
                            pc_q    <= pc_next;
                            state_q <= FETCH;
                        end
                        OP_LD, OP_ST, OP_ADD, OP_SUB: state_q <= MEM;
                        OP_BNZ: begin
                            pc_q    <= (acc_q != '0) ? operand_addr : pc_next;
                            state_q <= FETCH;
                        end
                        default: state_q <= HALTED; // OP_HALT and unknown codes
                    endcase
                end
                MEM: begin
                    if (wb_rsp_i.ack) begin
                        case (op)
                            OP_LD:   acc_q <= wb_rsp_i.rdata;
                            OP_ADD:  acc_q <= acc_q + wb_rsp_i.rdata;
                            OP_SUB:  acc_q <= acc_q - wb_rsp_i.rdata;
                            default: ;  // Store done by the memory
                        endcase
                        pc_q    <= pc_next;
                        state_q <= FETCH;
                    end
                end
                HALTED: state_q <= HALTED; // Left only when run drops
                default: state_q <= FETCH;
            endcase
        end
    end

    // Request held from the state until the ack cycle
    assign wb_req_o.cyc   = run_i && bus_state;
    assign wb_req_o.stb   = run_i && bus_state;
    assign wb_req_o.we    = (state_q == MEM) && (op == OP_ST);
    assign wb_req_o.addr  = (state_q == MEM) ? {22'b0, operand_addr, 2'b00}
                                             : {22'b0, pc_q, 2'b00};
    assign wb_req_o.wdata = acc_q;

    assign halted_o = state_q == HALTED;

endmodule

`default_nettype wire

// ==== hdl/processorci_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module processorci_top import harness_pkg::*; (
    input  logic     sys_clk_i,
    input  logic     rst_n_i,
    input  apb_req_t apb_req_i,
    output apb_rsp_t apb_rsp_o
);

    // Core side of the controller
    wb_req_t core_wb_req;
    wb_rsp_t core_wb_rsp;
    logic    core_run;
    logic    core_halted;

    harness_controller u_controller (
        .sys_clk_i     (sys_clk_i),
        .rst_n_i       (rst_n_i),
        .apb_req_i     (apb_req_i),
        .apb_rsp_o     (apb_rsp_o),
        .core_wb_req_i (core_wb_req),
        .core_wb_rsp_o (core_wb_rsp),
        .halted_i      (core_halted),
        .core_run_o    (core_run)
    );

    accum_core u_core (
        .sys_clk_i (sys_clk_i),
        .rst_n_i   (rst_n_i),
        .run_i     (core_run),  // Holds the core idle when low
        .wb_req_o  (core_wb_req),
        .wb_rsp_i  (core_wb_rsp),
        .halted_o  (core_halted)
    );

endmodule

`default_nettype wire

// ==== sim/processorci_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module processorci_properties import harness_pkg::*; (
    input logic     sys_clk_i,
    input logic     rst_n_i,
    input apb_req_t apb_req_i,
    input apb_rsp_t apb_rsp_i,
    input wb_req_t  core_req_i,
    input wb_rsp_t  core_rsp_i,
    input logic     run_i
);

    // Host word access completes one cycle into its access phase
    mem_data_wait_state: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        apb_rsp_i.pready && apb_req_i.paddr == REG_MEM_DATA && !apb_rsp_i.pslverr
        |-> $past(apb_req_i.psel && apb_req_i.penable))
        else $error("MEM_DATA access completed without its wait state");

    ack_with_request: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        core_rsp_i.ack |-> core_req_i.cyc && core_req_i.stb)
        else $error("Wishbone ack without cyc and stb");

    // Master holds its request until the ack
    request_stable: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        core_req_i.cyc && core_req_i.stb && !core_rsp_i.ack |=>
            core_req_i.cyc && core_req_i.stb && $stable(core_req_i.addr)
            && $stable(core_req_i.we) && $stable(core_req_i.wdata))
        else $error("Core request changed before its ack");

    // Run only drops once the core has no request waiting
    run_drop_after_ack: assert property (@(posedge sys_clk_i) disable iff (!rst_n_i)
        $fell(run_i) |-> $past(!core_req_i.cyc || core_rsp_i.ack))
        else $error("Run cleared while a core request was waiting for its ack");

endmodule

`default_nettype wire

// ==== sim/processorci_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module processorci_tb import harness_pkg::*; ();

    localparam int    CLK_PERIOD   = 40;
    localparam int    APB_WAIT_MAX = 20;
    localparam int    POLL_MAX     = 1500;   // STATUS reads per run
    localparam word_t SENTINEL     = 32'hC0DE_5A5A;

    localparam logic [1:0] KIND_ADD   = 2'd0;
    localparam logic [1:0] KIND_SUB   = 2'd1;
    localparam logic [1:0] KIND_COUNT = 2'd2;
    localparam logic [1:0] KIND_SPIN  = 2'd3;

    typedef struct packed {
        logic [1:0] kind;
        word_t      a;        // Countdown start for KIND_COUNT
        word_t      b;
        word_t      result;   // Expected word 0x42
        logic       timeout;
    } row_t;

    logic     sys_clk;
    logic     rst_n;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    row_t     run_table [8];
    integer   seed;

    processorci_top processorci_top_i (
        .sys_clk_i (sys_clk),
        .rst_n_i   (rst_n),
        .apb_req_i (apb_req),
        .apb_rsp_o (apb_rsp)
    );

    bind harness_controller processorci_properties u_properties (
        .sys_clk_i  (sys_clk_i),
        .rst_n_i    (rst_n_i),
        .apb_req_i  (apb_req_i),
        .apb_rsp_i  (apb_rsp_o),
        .core_req_i (core_wb_req_i),
        .core_rsp_i (core_wb_rsp_o),
        .run_i      (core_run_o)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            report_failure($sformatf("Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                                     $time, name, actual, expected));
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input word_t wdata,
                            input logic exp_err, output word_t rdata);
        int   waited;
        logic done;
        waited = 0;
        done   = 1'b0;
        @(negedge sys_clk);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge sys_clk);
        apb_req.penable = 1'b1;
        while (!done) begin
            #(CLK_PERIOD / 4); // Sample in the low phase
            if (apb_rsp.pready) begin
                done  = 1'b1;
                rdata = apb_rsp.prdata;
                check("pslverr", 32'(apb_rsp.pslverr), 32'(exp_err));
            end else if (waited == APB_WAIT_MAX) begin
                report_failure("APB slave never raised pready");
            end
            waited++;
            @(negedge sys_clk);
        end
        apb_req = '0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input word_t data);
        word_t unused;
        apb_xfer(1'b1, addr, data, 1'b0, unused);
    endtask

    task automatic read_check(input logic [7:0] addr, input word_t expected, input string name);
        word_t data;
        apb_xfer(1'b0, addr, '0, 1'b0, data);
        check(name, data, expected);
    endtask

    // Opcode in the top nibble, operand in the low half
    function automatic word_t instr(input opcode_t op, input logic [15:0] operand);
        return {op, 12'h000, operand};
    endfunction

    task automatic load_program(input row_t row);
        word_t prog [$];
        case (row.kind)
            KIND_COUNT: begin
                prog.push_back(instr(OP_LDI, row.a[15:0]));
                prog.push_back(instr(OP_SUB, 16'h0041));
                prog.push_back(instr(OP_BNZ, 16'h0001));
            end
            KIND_SPIN: begin
                prog.push_back(instr(OP_LDI, 16'h0001));
                prog.push_back(instr(OP_BNZ, 16'h0001)); // Branches to itself
            end
            default: begin
                prog.push_back(instr(OP_LD, 16'h0040));
                prog.push_back(instr(row.kind == KIND_ADD ? OP_ADD : OP_SUB, 16'h0041));
            end
        endcase
        prog.push_back(instr(OP_ST, 16'h0042));
        prog.push_back(instr(OP_HALT, 16'h0000));
        write_reg(REG_MEM_ADDR, 32'h0);
        foreach (prog[i]) begin
            write_reg(REG_MEM_DATA, prog[i]);
        end
        write_reg(REG_MEM_ADDR, 32'h40);
        write_reg(REG_MEM_DATA, row.a);
        write_reg(REG_MEM_DATA, row.b);
        write_reg(REG_MEM_DATA, SENTINEL); // Result cell
    endtask

    initial begin
        word_t words [4];
        word_t ra;
        word_t rb;
        word_t rd;
        word_t status;
        word_t cycles;
        word_t count_cycles;
        int    polls;

        apb_req      = '0;
        rst_n        = 1'b0;
        seed         = 13588;
        count_cycles = '0;

        run_table[0] = '{KIND_ADD, 32'd5, 32'd7, 32'd12, 1'b0};
        run_table[1] = '{KIND_ADD, 32'hFFFF_FFFF, 32'd2, 32'd1, 1'b0};
        run_table[2] = '{KIND_SUB, 32'd3, 32'd5, 32'hFFFF_FFFE, 1'b0};
        ra = $random(seed);
        rb = $random(seed);
        run_table[3] = '{KIND_ADD, ra, rb, ra + rb, 1'b0};
        ra = $random(seed);
        rb = $random(seed);
        run_table[4] = '{KIND_SUB, ra, rb, ra - rb, 1'b0};
        run_table[5] = '{KIND_COUNT, 32'd3, 32'd1, 32'd0, 1'b0};
        run_table[6] = '{KIND_COUNT, 32'd12, 32'd1, 32'd0, 1'b0};
        run_table[7] = '{KIND_SPIN, 32'd0, 32'd0, SENTINEL, 1'b1};

        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        read_check(REG_CTRL, 32'h0, "ctrl");
        read_check(REG_STATUS, 32'h0, "status");
        read_check(REG_CYCLES, 32'h0, "cycles");

        write_reg(REG_MEM_ADDR, 32'h80);
        for (int i = 0; i < 4; i++) begin
            words[i] = $random(seed);
            write_reg(REG_MEM_DATA, words[i]);
        end
        apb_xfer(1'b1, 8'h14, 32'hFFFF_FFFF, 1'b1, rd); // Unmapped offsets
        apb_xfer(1'b0, 8'h3C, '0, 1'b1, rd);
        read_check(REG_MEM_ADDR, 32'h84, "mem_addr");
        write_reg(REG_MEM_ADDR, 32'h80);
        for (int i = 0; i < 4; i++) begin
            read_check(REG_MEM_DATA, words[i], "mem_data");
        end

        foreach (run_table[i]) begin
            load_program(run_table[i]);
            write_reg(REG_CTRL, 32'h1);
            if (run_table[i].timeout) begin
                // Memory belongs to the core now
                write_reg(REG_MEM_ADDR, 32'h42);
                apb_xfer(1'b1, REG_MEM_DATA, 32'hBAD0_BAD0, 1'b1, rd);
                apb_xfer(1'b0, REG_MEM_DATA, '0, 1'b1, rd);
                read_check(REG_MEM_ADDR, 32'h42, "mem_addr");
            end
            status = '0;
            polls  = 0;
            while (status[1:0] == 2'b00) begin
                if (polls == POLL_MAX) begin
                    report_failure("Core neither halted nor timed out");
                end
                polls++;
                apb_xfer(1'b0, REG_STATUS, '0, 1'b0, status);
            end
            check("status", status, {30'b0, run_table[i].timeout, !run_table[i].timeout});
            read_check(REG_CTRL, 32'h0, "ctrl.run");
            write_reg(REG_MEM_ADDR, 32'h42);
            read_check(REG_MEM_DATA, run_table[i].result, "mem[0x42]");
            apb_xfer(1'b0, REG_CYCLES, '0, 1'b0, cycles);
            if (run_table[i].timeout) begin
                check("cycles", cycles, TIMEOUT_CYCLES);
            end else if (run_table[i].kind == KIND_COUNT) begin
                check("cycles growth", 32'(cycles > count_cycles), 32'h1);
                count_cycles = cycles;
            end
        end

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
hdl/harness_pkg.sv
hdl/harness_memory.sv
hdl/harness_controller.sv
hdl/accum_core.sv
hdl/processorci_top.sv
sim/processorci_properties.sv
sim/processorci_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and searches the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module processorci_tb \
    -f files.f -o processorci_sim \
    && ./obj_dir/processorci_sim | tee sim.log \
    || { echo "Build or run of the simulation did not complete"; exit 1; }

grep -q "Everything OK" sim.log && echo "Simulation passed" \
    || { echo "Simulation did not pass"; exit 1; }
